// ==== verilog.f ====
+incdir+.
audio_stream_pkg.sv
sample_buffer_ram.sv
buffer_copy_engine.sv
i2s_fifo_bridge.sv
audio_stream_top.sv
tb_audio_stream.sv

// ==== tb_audio_stream.sv ====
////////////////////
// audio stream testbench, host model,
// strobe driver and output checkers
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "audio_stream_consts.svh"

module tb_audio_stream;
	import audio_stream_pkg::*;

	localparam int NUM_BUFS = 6;
	localparam int EDGES = 40;
	// host writes, copy, polling, readback and led wait of one buffer
	localparam int BUF_CYCLES = 5 * (`AUD_MAX_SAMPLES + 64);
	localparam int STROBE_CYCLES = 2 * EDGES * 20 + 64;
	localparam int TIMEOUT = 20 + NUM_BUFS * BUF_CYCLES + STROBE_CYCLES;

	logic          clock_bridge_0_out_clk_clk;
	logic          hps_0_h2f_reset_reset_n;
	logic          in_host_we_i;
	buf_addr_t     in_host_addr_i;
	sample_t       in_host_wdata_i;
	sample_t       in_host_rdata_o;
	logic          out_host_we_i;
	buf_addr_t     out_host_addr_i;
	sample_t       out_host_wdata_i;
	sample_t       out_host_rdata_o;
	logic [7:0]    led_o;
	logic          rate_sel_44_i;
	logic          play_ack_48_i;
	logic          play_ack_44_i;
	logic          dacdat_48_i;
	logic          dacdat_44_i;
	logic          play_dma_enable_i;
	logic          play_fifo_empty_i;
	logic          cap_write_48_i;
	logic          cap_write_44_i;
	stereo_frame_t cap_frame_48_i;
	stereo_frame_t cap_frame_44_i;
	logic          cap_dma_enable_i;
	logic          cap_fifo_full_i;
	logic          play_fifo_read_o;
	logic          aud_dacdat_o;
	logic          play_enable_o;
	logic          cap_fifo_write_o;
	stereo_frame_t cap_fifo_data_o;
	logic          cap_enable_o;

	// host view of both RAMs
	sample_t in_model [`AUD_RAM_DEPTH];
	sample_t out_model [`AUD_RAM_DEPTH];

	logic [31:0] rng;
	int unsigned cyc;
	int unsigned play_pulses;
	int unsigned cap_pulses;
	int copy_errs;
	int interval_errs;
	int led_errs;
	int pulse_errs;
	int comb_errs;
	logic comb_on;
	logic comb_dac;
	logic [63:0] comb_frame;

	audio_stream_top dut (.*);

	always #5 clock_bridge_0_out_clk_clk = ~clock_bridge_0_out_clk_clk;

	always @(posedge clock_bridge_0_out_clk_clk)
		cyc <= cyc + 1;

	always @(negedge clock_bridge_0_out_clk_clk) begin
		if (cyc >= TIMEOUT) begin
			$display("timeout: run still busy after %0d cycles", TIMEOUT);
			$display("** FAIL **");
			$finish;
		end
	end

	// pulse counters, read back on the rising edge only
	always @(negedge clock_bridge_0_out_clk_clk) begin
		if (play_fifo_read_o === 1'b1)
			play_pulses = play_pulses + 1;
		if (cap_fifo_write_o === 1'b1)
			cap_pulses = cap_pulses + 1;
	end

	// payload mux and run gating, every cycle
	always @(negedge clock_bridge_0_out_clk_clk) begin
		if (comb_on) begin
			comb_dac = rate_sel_44_i ? dacdat_44_i : dacdat_48_i;
			comb_frame = rate_sel_44_i ? cap_frame_44_i : cap_frame_48_i;
			if (aud_dacdat_o !== comb_dac) begin
				comb_errs++;
				$display("[ERROR] aud_dacdat_o = 0x%h, expected 0x%h", aud_dacdat_o, comb_dac);
			end
			if (cap_fifo_data_o !== comb_frame) begin
				comb_errs++;
				$display("[ERROR] cap_fifo_data_o = 0x%h, expected 0x%h",
					cap_fifo_data_o, comb_frame);
			end
			if (play_enable_o !== (play_dma_enable_i & ~play_fifo_empty_i)) begin
				comb_errs++;
				$display("[ERROR] play_enable_o = 0x%h, expected 0x%h", play_enable_o,
					play_dma_enable_i & ~play_fifo_empty_i);
			end
			if (cap_enable_o !== (cap_dma_enable_i & ~cap_fifo_full_i)) begin
				comb_errs++;
				$display("[ERROR] cap_enable_o = 0x%h, expected 0x%h", cap_enable_o,
					cap_dma_enable_i & ~cap_fifo_full_i);
			end
		end
	end

	// two LCG steps per word, upper halves only
	function logic [31:0] rand_word(input int unsigned bits);
		logic [31:0] w;
		rng = rng * 32'd1664525 + 32'd1013904223;
		w[31:16] = rng[31:16];
		rng = rng * 32'd1664525 + 32'd1013904223;
		w[15:0] = rng[31:16];
		return (bits >= 32) ? w : (w & ((32'd1 << bits) - 1));
	endfunction

	function int unsigned pick_below(input int unsigned span);
		return rand_word(32) % span;
	endfunction

	task automatic write_word(input logic to_out, input buf_addr_t addr, input sample_t data);
		@(posedge clock_bridge_0_out_clk_clk);
		in_host_we_i <= !to_out;
		out_host_we_i <= to_out;
		if (to_out) begin
			out_host_addr_i <= addr;
			out_host_wdata_i <= data;
			out_model[addr] = data;
		end else begin
			in_host_addr_i <= addr;
			in_host_wdata_i <= data;
			in_model[addr] = data;
		end
	endtask

	task automatic release_host();
		@(posedge clock_bridge_0_out_clk_clk);
		in_host_we_i <= 1'b0;
		out_host_we_i <= 1'b0;
	endtask

	// registered read, data valid one cycle after the address
	task automatic read_word(input logic from_out, input buf_addr_t addr, output sample_t data);
		@(posedge clock_bridge_0_out_clk_clk);
		in_host_we_i <= 1'b0;
		out_host_we_i <= 1'b0;
		in_host_addr_i <= addr;
		out_host_addr_i <= addr;
		@(posedge clock_bridge_0_out_clk_clk);
		@(negedge clock_bridge_0_out_clk_clk);
		data = from_out ? out_host_rdata_o : in_host_rdata_o;
	endtask

	task automatic check_word(input logic from_out, input buf_addr_t addr,
		input sample_t expected, inout int errs);
		sample_t got;
		read_word(from_out, addr, got);
		if (got !== expected) begin
			errs++;
			$display("[ERROR] %s word 0x%03h = 0x%08h, expected 0x%08h",
				from_out ? "out_host_rdata_o" : "in_host_rdata_o", addr, got, expected);
		end
	endtask

	task automatic run_buffer(input int b, inout int unsigned prev_flag_cyc);
		int unsigned n;
		int unsigned n_copy;
		int unsigned flag_cyc;
		int unsigned wait_len;
		int i;
		sample_t word;
		logic [7:0] exp_led;
		n = pick_below(601);
		n_copy = (n > `AUD_MAX_SAMPLES) ? `AUD_MAX_SAMPLES : n;
		write_word(1'b0, `AUD_INFO_ADDR, sample_t'(n));
		for (i = 0; i < n_copy; i++)
			write_word(1'b0, buf_addr_t'(`AUD_SAMPLE_BASE + i), rand_word(32));
		write_word(1'b1, `AUD_FLAG_ADDR, '0);
		write_word(1'b0, `AUD_FLAG_ADDR, `AUD_FLAG_VALUE);
		// stamp of the edge that drives the flag write
		flag_cyc = cyc;
		release_host();
		word = '0;
		while (word !== `AUD_FLAG_VALUE)
			read_word(1'b1, `AUD_FLAG_ADDR, word);
		// engine result in the model
		for (i = 0; i < n_copy; i++)
			out_model[`AUD_SAMPLE_BASE + i] = in_model[`AUD_SAMPLE_BASE + i];
		out_model[`AUD_FLAG_ADDR] = `AUD_FLAG_VALUE;
		in_model[`AUD_FLAG_ADDR] = '0;
		for (i = 0; i < n_copy; i++)
			check_word(1'b1, buf_addr_t'(`AUD_SAMPLE_BASE + i),
				out_model[`AUD_SAMPLE_BASE + i], copy_errs);
		check_word(1'b0, `AUD_FLAG_ADDR, in_model[`AUD_FLAG_ADDR], copy_errs);
		if (b > 0) begin
			out_model[`AUD_INFO_ADDR] = sample_t'(flag_cyc - prev_flag_cyc);
			check_word(1'b1, `AUD_INFO_ADDR, out_model[`AUD_INFO_ADDR], interval_errs);
		end
		// counter is 1 on the edge after detection, 3 edges past the flag stamp
		wait_len = pick_below(300);
		repeat (wait_len) @(posedge clock_bridge_0_out_clk_clk);
		@(negedge clock_bridge_0_out_clk_clk);
		exp_led = cyc - flag_cyc - 3;
		if (led_o !== exp_led) begin
			led_errs++;
			$display("[ERROR] led_o = 0x%02h, expected 0x%02h", led_o, exp_led);
		end
		prev_flag_cyc = flag_cyc;
	endtask

	task automatic strobe_phase(input logic sel44);
		int unsigned hi_len;
		int unsigned lo_len;
		int unsigned play_base;
		int unsigned cap_base;
		int e;
		int c;
		logic level;
		@(posedge clock_bridge_0_out_clk_clk);
		rate_sel_44_i <= sel44;
		play_ack_48_i <= 1'b0;
		play_ack_44_i <= 1'b0;
		cap_write_48_i <= 1'b0;
		cap_write_44_i <= 1'b0;
		repeat (6) @(posedge clock_bridge_0_out_clk_clk);
		play_base = play_pulses;
		cap_base = cap_pulses;
		for (e = 0; e < EDGES; e++) begin
			// low for 7 or more, so falling edges land at least 8 cycles apart
			hi_len = 1 + pick_below(4);
			lo_len = 7 + pick_below(8);
			for (c = 0; c < hi_len + lo_len; c++) begin
				@(posedge clock_bridge_0_out_clk_clk);
				level = (c < hi_len);
				play_ack_44_i <= sel44 ? level : (rand_word(1) != 0);
				cap_write_44_i <= sel44 ? level : (rand_word(1) != 0);
				play_ack_48_i <= sel44 ? (rand_word(1) != 0) : level;
				cap_write_48_i <= sel44 ? (rand_word(1) != 0) : level;
				dacdat_48_i <= rand_word(1) != 0;
				dacdat_44_i <= rand_word(1) != 0;
				cap_frame_48_i <= {rand_word(32), rand_word(32)};
				cap_frame_44_i <= {rand_word(32), rand_word(32)};
				play_dma_enable_i <= rand_word(1) != 0;
				play_fifo_empty_i <= rand_word(1) != 0;
				cap_dma_enable_i <= rand_word(1) != 0;
				cap_fifo_full_i <= rand_word(1) != 0;
			end
		end
		@(posedge clock_bridge_0_out_clk_clk);
		play_ack_48_i <= 1'b0;
		cap_write_48_i <= 1'b0;
		play_ack_44_i <= 1'b0;
		cap_write_44_i <= 1'b0;
		repeat (8) @(posedge clock_bridge_0_out_clk_clk);
		if (play_pulses - play_base != EDGES) begin
			pulse_errs++;
			$display("[ERROR] play_fifo_read_o pulses = 0x%0h, expected 0x%0h (rate_sel_44_i %0d)",
				play_pulses - play_base, EDGES, sel44);
		end
		if (cap_pulses - cap_base != EDGES) begin
			pulse_errs++;
			$display("[ERROR] cap_fifo_write_o pulses = 0x%0h, expected 0x%0h (rate_sel_44_i %0d)",
				cap_pulses - cap_base, EDGES, sel44);
		end
	endtask

	initial begin
		int b;
		int unsigned prev_flag_cyc;
		int total;
		rng = 32'h1ae9c6ba;
		cyc = 0;
		play_pulses = 0;
		cap_pulses = 0;
		copy_errs = 0;
		interval_errs = 0;
		led_errs = 0;
		pulse_errs = 0;
		comb_errs = 0;
		comb_on = 1'b0;
		prev_flag_cyc = 0;
		clock_bridge_0_out_clk_clk = 1'b0;
		hps_0_h2f_reset_reset_n = 1'b0;
		in_host_we_i = 1'b0;
		in_host_addr_i = '0;
		in_host_wdata_i = '0;
		out_host_we_i = 1'b0;
		out_host_addr_i = '0;
		out_host_wdata_i = '0;
		rate_sel_44_i = 1'b0;
		play_ack_48_i = 1'b0;
		play_ack_44_i = 1'b0;
		dacdat_48_i = 1'b0;
		dacdat_44_i = 1'b0;
		play_dma_enable_i = 1'b0;
		play_fifo_empty_i = 1'b1;
		cap_write_48_i = 1'b0;
		cap_write_44_i = 1'b0;
		cap_frame_48_i = '0;
		cap_frame_44_i = '0;
		cap_dma_enable_i = 1'b0;
		cap_fifo_full_i = 1'b0;
		repeat (10) @(posedge clock_bridge_0_out_clk_clk);
		hps_0_h2f_reset_reset_n <= 1'b1;
		comb_on = 1'b1;
		for (b = 0; b < NUM_BUFS; b++)
			run_buffer(b, prev_flag_cyc);
		strobe_phase(1'b0);
		strobe_phase(1'b1);
		total = copy_errs + interval_errs + led_errs + pulse_errs + comb_errs;
		$display("errors: copy %0d, interval %0d, led %0d, pulse %0d, payload %0d, total %0d",
			copy_errs, interval_errs, led_errs, pulse_errs, comb_errs, total);
		if (total == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== audio_stream_top.sv ====
////////////////////
// audio stream top, sample RAMs,
// copy engine and i2s bridges
////////////////////

`timescale 1ns/1ps
`default_nettype none

module audio_stream_top (
	input  wire logic                          clock_bridge_0_out_clk_clk,
	input  wire logic                          hps_0_h2f_reset_reset_n,
	input  wire logic                          in_host_we_i,
	input  wire audio_stream_pkg::buf_addr_t    in_host_addr_i,
	input  wire audio_stream_pkg::sample_t      in_host_wdata_i,
	output audio_stream_pkg::sample_t           in_host_rdata_o,
	input  wire logic                          out_host_we_i,
	input  wire audio_stream_pkg::buf_addr_t    out_host_addr_i,
	input  wire audio_stream_pkg::sample_t      out_host_wdata_i,
	output audio_stream_pkg::sample_t           out_host_rdata_o,
	output logic [7:0]                         led_o,
	input  wire logic                          rate_sel_44_i,
	input  wire logic                          play_ack_48_i,
	input  wire logic                          play_ack_44_i,
	input  wire logic                          dacdat_48_i,
	input  wire logic                          dacdat_44_i,
	input  wire logic                          play_dma_enable_i,
	input  wire logic                          play_fifo_empty_i,
	input  wire logic                          cap_write_48_i,
	input  wire logic                          cap_write_44_i,
	input  wire audio_stream_pkg::stereo_frame_t cap_frame_48_i,
	input  wire audio_stream_pkg::stereo_frame_t cap_frame_44_i,
	input  wire logic                          cap_dma_enable_i,
	input  wire logic                          cap_fifo_full_i,
	output logic                               play_fifo_read_o,
	output logic                               aud_dacdat_o,
	output logic                               play_enable_o,
	output logic                               cap_fifo_write_o,
	output audio_stream_pkg::stereo_frame_t     cap_fifo_data_o,
	output logic                               cap_enable_o
);
	import audio_stream_pkg::*;

	// engine side of the two RAMs
	sample_t   eng_in_rdata;
	logic      eng_in_we;
	buf_addr_t eng_in_addr;
	sample_t   eng_in_wdata;
	logic      eng_out_we;
	buf_addr_t eng_out_addr;
	sample_t   eng_out_wdata;

	// host posts samples here
	sample_buffer_ram in_buf (
		.clock_bridge_0_out_clk_clk (clock_bridge_0_out_clk_clk),
		.hps_0_h2f_reset_reset_n    (hps_0_h2f_reset_reset_n),
		.a_we_i                     (in_host_we_i),
		.a_addr_i                   (in_host_addr_i),
		.a_wdata_i                  (in_host_wdata_i),
		.a_rdata_o                  (in_host_rdata_o),
		.b_we_i                     (eng_in_we),
		.b_addr_i                   (eng_in_addr),
		.b_wdata_i                  (eng_in_wdata),
		.b_rdata_o                  (eng_in_rdata)
	);

	// engine only writes here, no read back
	sample_buffer_ram out_buf (
		.clock_bridge_0_out_clk_clk (clock_bridge_0_out_clk_clk),
		.hps_0_h2f_reset_reset_n    (hps_0_h2f_reset_reset_n),
		.a_we_i                     (out_host_we_i),
		.a_addr_i                   (out_host_addr_i),
		.a_wdata_i                  (out_host_wdata_i),
		.a_rdata_o                  (out_host_rdata_o),
		.b_we_i                     (eng_out_we),
		.b_addr_i                   (eng_out_addr),
		.b_wdata_i                  (eng_out_wdata),
		.b_rdata_o                  ()
	);

	buffer_copy_engine copy_engine (
		.clock_bridge_0_out_clk_clk (clock_bridge_0_out_clk_clk),
		.hps_0_h2f_reset_reset_n    (hps_0_h2f_reset_reset_n),
		.in_rdata_i                 (eng_in_rdata),
		.in_we_o                    (eng_in_we),
		.in_addr_o                  (eng_in_addr),
		.in_wdata_o                 (eng_in_wdata),
		.out_we_o                   (eng_out_we),
		.out_addr_o                 (eng_out_addr),
		.out_wdata_o                (eng_out_wdata),
		.led_o                      (led_o)
	);

	// playback ready means FIFO not empty
	i2s_fifo_bridge #(
		.payload_t (logic)
	) play_bridge (
		.clock_bridge_0_out_clk_clk (clock_bridge_0_out_clk_clk),
		.hps_0_h2f_reset_reset_n    (hps_0_h2f_reset_reset_n),
		.rate_sel_44_i              (rate_sel_44_i),
		.strobe_48_i                (play_ack_48_i),
		.strobe_44_i                (play_ack_44_i),
		.payload_48_i               (dacdat_48_i),
		.payload_44_i               (dacdat_44_i),
		.dma_enable_i               (play_dma_enable_i),
		.fifo_ready_i               (~play_fifo_empty_i),
		.fifo_pulse_o               (play_fifo_read_o),
		.payload_o                  (aud_dacdat_o),
		.run_o                      (play_enable_o)
	);

	// capture ready means FIFO not full
	i2s_fifo_bridge #(
		.payload_t (stereo_frame_t)
	) cap_bridge (
		.clock_bridge_0_out_clk_clk (clock_bridge_0_out_clk_clk),
		.hps_0_h2f_reset_reset_n    (hps_0_h2f_reset_reset_n),
		.rate_sel_44_i              (rate_sel_44_i),
		.strobe_48_i                (cap_write_48_i),
		.strobe_44_i                (cap_write_44_i),
		.payload_48_i               (cap_frame_48_i),
		.payload_44_i               (cap_frame_44_i),
		.dma_enable_i               (cap_dma_enable_i),
		.fifo_ready_i               (~cap_fifo_full_i),
		.fifo_pulse_o               (cap_fifo_write_o),
		.payload_o                  (cap_fifo_data_o),
		.run_o                      (cap_enable_o)
	);

endmodule

`default_nettype wire

// ==== i2s_fifo_bridge.sv ====
////////////////////
// i2s FIFO strobe sync, rate mux
// and run gating
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "audio_stream_consts.svh"

module i2s_fifo_bridge #(
	parameter type payload_t = logic
) (
	input  wire logic     clock_bridge_0_out_clk_clk,
	input  wire logic     hps_0_h2f_reset_reset_n,
	input  wire logic     rate_sel_44_i,
	input  wire logic     strobe_48_i,
	input  wire logic     strobe_44_i,
	input  wire payload_t payload_48_i,
	input  wire payload_t payload_44_i,
	input  wire logic     dma_enable_i,
	input  wire logic     fifo_ready_i,
	output logic          fifo_pulse_o,
	output payload_t      payload_o,
	output logic          run_o
);

	logic strobe_sel;
	logic [`AUD_SYNC_STAGES-1:0] sync_q;

	// 44.1 kHz path when rate_sel_44_i is high
	assign strobe_sel = rate_sel_44_i ? strobe_44_i : strobe_48_i;
	assign payload_o = rate_sel_44_i ? payload_44_i : payload_48_i;

	// strobe comes from the i2s bit clock domain
	always_ff @(posedge clock_bridge_0_out_clk_clk or negedge hps_0_h2f_reset_reset_n) begin
		if (!hps_0_h2f_reset_reset_n)
			sync_q <= '0;
		else
			sync_q <= {sync_q[`AUD_SYNC_STAGES-2:0], strobe_sel};
	end

	// falling edge, one cycle wide
	assign fifo_pulse_o = sync_q[`AUD_SYNC_STAGES-1] & ~sync_q[`AUD_SYNC_STAGES-2];

	// stall the shifter when DMA is off or the FIFO cannot take more
	assign run_o = dma_enable_i & fifo_ready_i;

endmodule

`default_nettype wire

// ==== buffer_copy_engine.sv ====
////////////////////
// flag polling, pipelined block copy,
// interval counter and acknowledge
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "audio_stream_consts.svh"

module buffer_copy_engine (
	input  wire logic                       clock_bridge_0_out_clk_clk,
	input  wire logic                       hps_0_h2f_reset_reset_n,
	input  wire audio_stream_pkg::sample_t   in_rdata_i,
	output logic                            in_we_o,
	output audio_stream_pkg::buf_addr_t      in_addr_o,
	output audio_stream_pkg::sample_t        in_wdata_o,
	output logic                            out_we_o,
	output audio_stream_pkg::buf_addr_t      out_addr_o,
	output audio_stream_pkg::sample_t        out_wdata_o,
	output logic [7:0]                      led_o
);
	import audio_stream_pkg::*;

	copy_state_t state_q;

	// clamped block length and next sample to read
	buf_addr_t n_cnt_q;
	buf_addr_t rd_idx_q;

	// read in flight, data shows up on in_rdata_i
	logic      rd_valid_q;
	buf_addr_t rd_tag_q;

	// returned sample waiting for its write
	logic      wr_valid_q;
	buf_addr_t wr_tag_q;
	sample_t   wr_data_q;

	logic [`AUD_SAMPLE_W-1:0] interval_q;

	logic detect;
	logic issue;
	logic over_max;

	assign detect = (state_q == st_idle) && (in_rdata_i == `AUD_FLAG_VALUE);
	assign issue = (state_q == st_copy) && (rd_idx_q < n_cnt_q);

	// count word read as unsigned before the clamp
	assign over_max = $unsigned(in_rdata_i) > `AUD_MAX_SAMPLES;

	always_ff @(posedge clock_bridge_0_out_clk_clk or negedge hps_0_h2f_reset_reset_n) begin
		if (!hps_0_h2f_reset_reset_n) begin
			state_q <= st_idle;
			n_cnt_q <= '0;
			rd_idx_q <= '0;
		end else begin
			case (state_q)
				st_idle: begin
					if (detect)
						state_q <= st_read_count;
				end
				st_read_count: begin
					// count word returns one cycle after detection
					if (over_max)
						n_cnt_q <= `AUD_MAX_SAMPLES;
					else
						n_cnt_q <= buf_addr_t'(in_rdata_i);
					rd_idx_q <= '0;
					state_q <= st_copy;
				end
				st_copy: begin
					if (issue)
						rd_idx_q <= rd_idx_q + 1'b1;
					// leave once the last read goes out, or at once for an empty block
					if (rd_idx_q + 1'b1 >= n_cnt_q)
						state_q <= st_finish;
				end
				st_finish: begin
					// last sample is written in the cycle rd_valid_q drops
					if (!rd_valid_q)
						state_q <= st_ack;
				end
				st_ack: begin
					state_q <= st_idle;
				end
				default: begin
					state_q <= st_idle;
				end
			endcase
		end
	end

	// copy pipeline valid bits
	always_ff @(posedge clock_bridge_0_out_clk_clk or negedge hps_0_h2f_reset_reset_n) begin
		if (!hps_0_h2f_reset_reset_n) begin
			rd_valid_q <= 1'b0;
			wr_valid_q <= 1'b0;
		end else begin
			rd_valid_q <= issue;
			wr_valid_q <= rd_valid_q;
		end
	end

	always_ff @(posedge clock_bridge_0_out_clk_clk) begin
		rd_tag_q <= rd_idx_q;
		wr_tag_q <= rd_tag_q;
		wr_data_q <= in_rdata_i;
	end

	// free running, detection cycle is cycle 0 of the next interval
	always_ff @(posedge clock_bridge_0_out_clk_clk or negedge hps_0_h2f_reset_reset_n) begin
		if (!hps_0_h2f_reset_reset_n)
			interval_q <= '0;
		else if (detect)
			interval_q <= 1;
		else
			interval_q <= interval_q + 1'b1;
	end

	assign led_o = interval_q[7:0];

	// RAM port decode
	always_comb begin
		in_we_o = 1'b0;
		in_addr_o = `AUD_FLAG_ADDR;
		in_wdata_o = '0;
		out_we_o = 1'b0;
		out_addr_o = `AUD_FLAG_ADDR;
		out_wdata_o = '0;
		case (state_q)
			st_idle: begin
				if (detect) begin
					in_addr_o = `AUD_INFO_ADDR;
					out_we_o = 1'b1;
					out_addr_o = `AUD_INFO_ADDR;
					out_wdata_o = sample_t'(interval_q);
				end
			end
			st_copy: begin
				if (issue)
					in_addr_o = `AUD_SAMPLE_BASE + rd_idx_q;
			end
			st_ack: begin
				// clear the host flag and raise ours together
				in_we_o = 1'b1;
				out_we_o = 1'b1;
				out_wdata_o = `AUD_FLAG_VALUE;
			end
			default: begin
			end
		endcase
		if (wr_valid_q) begin
			out_we_o = 1'b1;
			out_addr_o = `AUD_SAMPLE_BASE + wr_tag_q;
			out_wdata_o = wr_data_q;
		end
	end

endmodule

`default_nettype wire

// ==== sample_buffer_ram.sv ====
////////////////////
// two-port sample RAM, registered reads
////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "audio_stream_consts.svh"

module sample_buffer_ram (
	input  wire logic                       clock_bridge_0_out_clk_clk,
	input  wire logic                       hps_0_h2f_reset_reset_n,
	input  wire logic                       a_we_i,
	input  wire audio_stream_pkg::buf_addr_t a_addr_i,
	input  wire audio_stream_pkg::sample_t   a_wdata_i,
	output audio_stream_pkg::sample_t        a_rdata_o,
	input  wire logic                       b_we_i,
	input  wire audio_stream_pkg::buf_addr_t b_addr_i,
	input  wire audio_stream_pkg::sample_t   b_wdata_i,
	output audio_stream_pkg::sample_t        b_rdata_o
);
	import audio_stream_pkg::*;

	sample_t mem [`AUD_RAM_DEPTH];

	// both ports may write, same address at once is undefined
	always_ff @(posedge clock_bridge_0_out_clk_clk) begin
		if (a_we_i)
			mem[a_addr_i] <= a_wdata_i;
		if (b_we_i)
			mem[b_addr_i] <= b_wdata_i;
	end

	// a write returns the new word on its own port
	always_ff @(posedge clock_bridge_0_out_clk_clk or negedge hps_0_h2f_reset_reset_n) begin
		if (!hps_0_h2f_reset_reset_n) begin
			a_rdata_o <= '0;
			b_rdata_o <= '0;
		end else begin
			if (a_we_i)
				a_rdata_o <= a_wdata_i;
			else
				a_rdata_o <= mem[a_addr_i];
			if (b_we_i)
				b_rdata_o <= b_wdata_i;
			else
				b_rdata_o <= mem[b_addr_i];
		end
	end

endmodule

`default_nettype wire

// ==== audio_stream_pkg.sv ====
////////////////////
// sample, address, frame and copy FSM types
////////////////////

`default_nettype none

`include "audio_stream_consts.svh"

package audio_stream_pkg;

	// one RAM word, also one audio sample
	typedef logic signed [`AUD_SAMPLE_W-1:0] sample_t;

	// word address into either sample RAM
	typedef logic [`AUD_ADDR_W-1:0] buf_addr_t;

	// capture frame, right channel on top
	typedef struct packed {
		logic [`AUD_SAMPLE_W-1:0] right;
		logic [`AUD_SAMPLE_W-1:0] left;
	} stereo_frame_t;

	// copy engine states
	typedef enum logic [2:0] {
		st_idle,
		st_read_count,
		st_copy,
		st_finish,
		st_ack
	} copy_state_t;

endpackage

`default_nettype wire

// ==== audio_stream_consts.svh ====
////////////////////
// widths, buffer map, flag value and
// synchroniser depth for the audio stream
////////////////////

`ifndef AUDIO_STREAM_CONSTS_SVH
`define AUDIO_STREAM_CONSTS_SVH

// word and address widths
`define AUD_SAMPLE_W 32
`define AUD_ADDR_W 10
`define AUD_RAM_DEPTH 1024

// buffer map, shared by the input and output RAM
`define AUD_FLAG_ADDR 10'd0
`define AUD_INFO_ADDR 10'd1
`define AUD_SAMPLE_BASE 10'd512
`define AUD_MAX_SAMPLES 10'd512

// word 0 holds this value when a buffer is ready
`define AUD_FLAG_VALUE 32'h0000abcd

// flops on the i2s strobe before edge detect
`define AUD_SYNC_STAGES 3

`endif
